// File: hw/byte_lane_imem.sv
`timescale 1ns/1ps

module byte_lane_imem (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::word_t    rd_data_o
);

    import mem_sys_pkg::*;

    logic [OFF_W-1:0]   off;
    logic [OFF_W-1:0]   off_q;
    logic [IMEM_AW-1:0] base_idx;
    logic [BYTE_W-1:0]  lane_q [NUM_LANES];
    word_t              lane_word;
    logic [2*XLEN-1:0]  lane_dbl;

    assign off      = req_i.addr[OFF_W-1:0];
    assign base_idx = req_i.addr[IMEM_AW+OFF_W-1:OFF_W];

    // One byte-wide bank per lane
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        logic [BYTE_W-1:0]  mem [IMEM_WORDS];
        logic [IMEM_AW-1:0] idx;

        // Lanes below the start byte come from the next word
        assign idx = base_idx + IMEM_AW'(off > OFF_W'(k));

        always_ff @(posedge clk_i) begin
            if (req_i.write && req_i.be[k]) begin
                mem[idx] <= req_i.wdata[BYTE_W*k +: BYTE_W];
            end
            if (req_i.read) begin
                lane_q[k] <= mem[idx];
            end
        end
    end

    // Byte offset of the last read, selects the rotation
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            off_q <= '0;
        end else if (req_i.read) begin
            off_q <= off;
        end
    end

    always_comb begin
        for (int j = 0; j < NUM_LANES; j++) begin
            lane_word[BYTE_W*j +: BYTE_W] = lane_q[j];
        end
    end

    // Rotate right by the offset so byte A lands in bits 7:0
    assign lane_dbl  = {lane_word, lane_word} >> (BYTE_W * off_q);
    assign rd_data_o = lane_dbl[XLEN-1:0];

    // Lane indices and rotation need a known address on every access
    a_addr_known : assert property (
        @(posedge clk_i) disable iff (!rv_rst_ni)
        (req_i.read || req_i.write) |-> !$isunknown(req_i.addr[IMEM_AW+OFF_W-1:0])
    );

endmodule

// File: hw/mem_bus_decode.sv
`timescale 1ns/1ps

module mem_bus_decode (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,

    // Master side
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::word_t    rd_data_o,

    // Slave requests
    output mem_sys_pkg::mem_req_t imem_req_o,
    output mem_sys_pkg::mem_req_t dmem_req_o,
    output mem_sys_pkg::mem_req_t buf0_req_o,
    output mem_sys_pkg::mem_req_t buf1_req_o,

    // Slave read words, one cycle after the strobe
    input  mem_sys_pkg::word_t    imem_rd_i,
    input  mem_sys_pkg::word_t    dmem_rd_i,
    input  mem_sys_pkg::word_t    buf0_rd_i,
    input  mem_sys_pkg::word_t    buf1_rd_i,

    // PIM port
    input  mem_sys_pkg::word_t    pim_rd_i,
    output mem_sys_pkg::word_t    pim_addr_o,
    output mem_sys_pkg::word_t    pim_wr_o
);

    import mem_sys_pkg::*;

    region_e region;
    region_e region_q;
    word_t   pim_rd_q;
    logic    pim_read;
    logic    pim_write;

    // Keep address, data and be; only the strobes depend on the region
    function automatic mem_req_t gate_req(mem_req_t req, logic sel);
        mem_req_t out;
        out       = req;
        out.read  = req.read & sel;
        out.write = req.write & sel;
        return out;
    endfunction

    assign region = addr_region(req_i.addr);

    // Strobes go straight through to the selected slave
    assign imem_req_o = gate_req(req_i, region == REG_IMEM);
    assign dmem_req_o = gate_req(req_i, region == REG_DMEM);
    assign buf0_req_o = gate_req(req_i, region == REG_BUF0);
    assign buf1_req_o = gate_req(req_i, region == REG_BUF1);

    assign pim_read  = req_i.read & (region == REG_PIM);
    assign pim_write = req_i.write & (region == REG_PIM);

    // Region of the read in flight, REG_NONE when idle
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            region_q <= REG_NONE;
        end else if (req_i.read) begin
            region_q <= region;
        end else begin
            region_q <= REG_NONE;
        end
    end

    // PIM read value taken at the strobe edge, like an SRAM output
    always_ff @(posedge clk_i) begin
        if (pim_read) begin
            pim_rd_q <= pim_rd_i;
        end
    end

    // Read return mux, lines up with the one-cycle SRAM latency
    always_comb begin
        case (region_q)
            REG_IMEM: rd_data_o = imem_rd_i;
            REG_DMEM: rd_data_o = dmem_rd_i;
            REG_BUF0: rd_data_o = buf0_rd_i;
            REG_BUF1: rd_data_o = buf1_rd_i;
            REG_PIM:  rd_data_o = pim_rd_q;
            default:  rd_data_o = '0;
        endcase
    end

    // PIM address and write data, held until the next PIM write
    always_ff @(posedge clk_i or negedge rv_rst_ni) begin
        if (!rv_rst_ni) begin
            pim_addr_o <= '0;
            pim_wr_o   <= '0;
        end else if (pim_write) begin
            pim_addr_o <= req_i.addr;
            pim_wr_o   <= req_i.wdata;
        end
    end

    // Single master never reads and writes in the same cycle
    a_no_rd_wr : assert property (
        @(posedge clk_i) disable iff (!rv_rst_ni)
        !(req_i.read && req_i.write)
    );

endmodule

// File: hw/mem_sys_pkg.sv
package mem_sys_pkg;

    // Bus widths
    localparam int unsigned XLEN      = 32;
    localparam int unsigned NUM_LANES = XLEN / 8;
    localparam int unsigned BYTE_W    = 8;
    localparam int unsigned OFF_W     = $clog2(NUM_LANES);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [NUM_LANES-1:0] be_t;

    // One access from the external master
    typedef struct packed {
        logic  read;
        logic  write;
        be_t   be;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // Address map, matched on the top byte
    localparam word_t REGION_MASK = 32'hFF00_0000;
    localparam word_t IMEM_BASE   = 32'h1000_0000;
    localparam word_t DMEM_BASE   = 32'h2000_0000;
    localparam word_t BUF0_BASE   = 32'h3000_0000;
    localparam word_t BUF1_BASE   = 32'h3100_0000;
    localparam word_t PIM_BASE    = 32'h4000_0000;

    // Storage depths in words
    localparam int unsigned IMEM_WORDS = 1024;
    localparam int unsigned DMEM_WORDS = 1024;
    localparam int unsigned BUF_WORDS  = 4096;

    // Word index width of one instruction byte lane
    localparam int unsigned IMEM_AW = $clog2(IMEM_WORDS);

    typedef enum logic [2:0] {
        REG_IMEM = 3'd0,
        REG_DMEM = 3'd1,
        REG_BUF0 = 3'd2,
        REG_BUF1 = 3'd3,
        REG_PIM  = 3'd4,
        REG_NONE = 3'd7
    } region_e;

    // Slave selected by a bus address
    function automatic region_e addr_region(word_t addr);
        word_t top;
        top = addr & REGION_MASK;
        if (top == IMEM_BASE) return REG_IMEM;
        if (top == DMEM_BASE) return REG_DMEM;
        if (top == BUF0_BASE) return REG_BUF0;
        if (top == BUF1_BASE) return REG_BUF1;
        if (top == PIM_BASE)  return REG_PIM;
        return REG_NONE;
    endfunction

endpackage

// File: hw/pim_mem_sys.sv
`timescale 1ns/1ps

module pim_mem_sys (
    input  logic                  clk_i,
    input  logic                  rv_rst_ni,

    // External master
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::word_t    rd_data_o,

    // PIM port
    input  mem_sys_pkg::word_t    pim_rd_i,
    output mem_sys_pkg::word_t    pim_addr_o,
    output mem_sys_pkg::word_t    pim_wr_o
);

    import mem_sys_pkg::*;

    // Requests from the decoder to each slave
    mem_req_t imem_req;
    mem_req_t dmem_req;
    mem_req_t buf0_req;
    mem_req_t buf1_req;

    // Raw read words back from the slaves
    word_t    imem_rd;
    word_t    dmem_rd;
    word_t    buf0_rd;
    word_t    buf1_rd;

    mem_bus_decode u_decode (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .req_i      (req_i),
        .imem_req_o (imem_req),
        .dmem_req_o (dmem_req),
        .buf0_req_o (buf0_req),
        .buf1_req_o (buf1_req),
        .imem_rd_i  (imem_rd),
        .dmem_rd_i  (dmem_rd),
        .buf0_rd_i  (buf0_rd),
        .buf1_rd_i  (buf1_rd),
        .pim_rd_i   (pim_rd_i),
        .rd_data_o  (rd_data_o),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o)
    );

    // Instruction memory, unaligned word reads
    byte_lane_imem u_imem (
        .clk_i     (clk_i),
        .rv_rst_ni (rv_rst_ni),
        .req_i     (imem_req),
        .rd_data_o (imem_rd)
    );

    // Data memory
    word_sram #(
        .DEPTH (DMEM_WORDS)
    ) u_dmem (
        .clk_i     (clk_i),
        .req_i     (dmem_req),
        .rd_data_o (dmem_rd)
    );

    // Weight and activation buffers
    word_sram #(
        .DEPTH (BUF_WORDS)
    ) u_buf0 (
        .clk_i     (clk_i),
        .req_i     (buf0_req),
        .rd_data_o (buf0_rd)
    );

    word_sram #(
        .DEPTH (BUF_WORDS)
    ) u_buf1 (
        .clk_i     (clk_i),
        .req_i     (buf1_req),
        .rd_data_o (buf1_rd)
    );

endmodule

// File: hw/word_sram.sv
`timescale 1ns/1ps

module word_sram #(
    parameter int DEPTH = 1024
) (
    input  logic                  clk_i,
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::word_t    rd_data_o
);

    import mem_sys_pkg::*;

    localparam int AW = $clog2(DEPTH);

    word_t         mem [DEPTH];
    word_t         rd_q;
    logic [AW-1:0] idx;

    // Word index, byte offset bits dropped
    assign idx = req_i.addr[AW+OFF_W-1:OFF_W];

    // Byte-masked write port
    always_ff @(posedge clk_i) begin
        if (req_i.write) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (req_i.be[i]) begin
                    mem[idx][BYTE_W*i +: BYTE_W] <= req_i.wdata[BYTE_W*i +: BYTE_W];
                end
            end
        end
    end

    // Registered read, output holds until the next read
    always_ff @(posedge clk_i) begin
        if (req_i.read) begin
            rd_q <= mem[idx];
        end
    end

    assign rd_data_o = rd_q;

    // A write strobe from the master always carries some byte
    a_wr_be : assert property (
        @(posedge clk_i)
        req_i.write |-> |req_i.be
    );

endmodule

// File: pim_mem_sys.f
+incdir+verif
hw/mem_sys_pkg.sv
hw/mem_bus_decode.sv
hw/byte_lane_imem.sv
hw/word_sram.sv
hw/pim_mem_sys.sv
verif/tb_pim_mem_sys.sv

// File: verif/tb_vectors.svh
// Table operations
typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_PIMSET,
    OP_PIMCHK
} op_e;

// One table row; for OP_PIMCHK addr and data are the expected PIM outputs
typedef struct packed {
    op_e   op;
    word_t addr;
    be_t   be;
    word_t data;
    word_t expv;
} vector_t;

vector_t vectors[$];

task automatic add_vector(input op_e op, input word_t addr, input be_t be,
                          input word_t data, input word_t expv);
    vector_t v;
    v.op   = op;
    v.addr = addr;
    v.be   = be;
    v.data = data;
    v.expv = expv;
    vectors.push_back(v);
endtask

task automatic load_vectors();
    // DMEM partial write merges bytes 1 and 3
    add_vector(OP_WR, DMEM_BASE + 32'h10, 4'hF, 32'hA1B2_C3D4, '0);
    add_vector(OP_WR, DMEM_BASE + 32'h10, 4'b1010, 32'h5566_7788, '0);
    add_vector(OP_RD, DMEM_BASE + 32'h10, 4'hF, '0, 32'h55B2_77D4);
    // Same offset in both buffers
    add_vector(OP_WR, BUF0_BASE + 32'h20, 4'hF, 32'hB0B0_0001, '0);
    add_vector(OP_WR, BUF1_BASE + 32'h20, 4'hF, 32'hB1B1_0002, '0);
    add_vector(OP_RD, BUF0_BASE + 32'h20, 4'hF, '0, 32'hB0B0_0001);
    add_vector(OP_RD, BUF1_BASE + 32'h20, 4'hF, '0, 32'hB1B1_0002);
    // Last word of a buffer
    add_vector(OP_WR, BUF1_BASE + 32'h3FFC, 4'hF, 32'h1F1F_0FFF, '0);
    add_vector(OP_RD, BUF1_BASE + 32'h3FFC, 4'hF, '0, 32'h1F1F_0FFF);
    // Bytes 11..88 at IMEM offset 0x100, then reads from each start byte
    add_vector(OP_WR, IMEM_BASE + 32'h100, 4'hF, 32'h4433_2211, '0);
    add_vector(OP_WR, IMEM_BASE + 32'h104, 4'hF, 32'h8877_6655, '0);
    add_vector(OP_RD, IMEM_BASE + 32'h100, 4'hF, '0, 32'h4433_2211);
    add_vector(OP_RD, IMEM_BASE + 32'h101, 4'hF, '0, 32'h5544_3322);
    add_vector(OP_RD, IMEM_BASE + 32'h102, 4'hF, '0, 32'h6655_4433);
    add_vector(OP_RD, IMEM_BASE + 32'h103, 4'hF, '0, 32'h7766_5544);
    // PIM outputs follow a write and then hold
    add_vector(OP_WR, PIM_BASE + 32'h8, 4'hF, 32'hCAFE_0008, '0);
    add_vector(OP_PIMCHK, PIM_BASE + 32'h8, 4'h0, 32'hCAFE_0008, '0);
    add_vector(OP_WR, DMEM_BASE + 32'h20, 4'hF, 32'h0000_5A5A, '0);
    add_vector(OP_PIMCHK, PIM_BASE + 32'h8, 4'h0, 32'hCAFE_0008, '0);
    // PIM read returns the input seen at the strobe edge
    add_vector(OP_PIMSET, '0, 4'h0, 32'h1234_5678, '0);
    add_vector(OP_RD, PIM_BASE, 4'hF, '0, 32'h1234_5678);
    add_vector(OP_PIMSET, '0, 4'h0, 32'h9ABC_DEF0, '0);
    add_vector(OP_RD, PIM_BASE + 32'h4, 4'hF, '0, 32'h9ABC_DEF0);
    // Unmapped region
    add_vector(OP_RD, 32'h5000_0000, 4'hF, '0, 32'h0000_0000);
    add_vector(OP_WR, DMEM_BASE + 32'h40, 4'hF, 32'h0D0D_0D0D, '0);
    add_vector(OP_WR, 32'h5000_0040, 4'hF, 32'hFFFF_FFFF, '0);
    add_vector(OP_RD, DMEM_BASE + 32'h40, 4'hF, '0, 32'h0D0D_0D0D);
endtask

// File: verif/tb_pim_mem_sys.sv
`timescale 1ns/1ps

module tb_pim_mem_sys;

    import mem_sys_pkg::*;

    `include "tb_vectors.svh"

    logic     clk_i;
    logic     rv_rst_ni;
    mem_req_t req_i;
    word_t    pim_rd_i;
    word_t    rd_data_o;
    word_t    pim_addr_o;
    word_t    pim_wr_o;

    int n_pass = 0;
    int n_fail = 0;
    bit released;

    pim_mem_sys u_dut (
        .clk_i      (clk_i),
        .rv_rst_ni  (rv_rst_ni),
        .req_i      (req_i),
        .rd_data_o  (rd_data_o),
        .pim_rd_i   (pim_rd_i),
        .pim_addr_o (pim_addr_o),
        .pim_wr_o   (pim_wr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        rv_rst_ni = 1'b0;
        repeat (16) @(posedge clk_i);
        rv_rst_ni <= 1'b1;
    end

    // Only the first mismatch of a test is printed
    task automatic check_word(input string name, input word_t expv, input word_t got,
                              inout bit ok);
        if (ok && got !== expv) begin
            $display("Fail %s exp %08h got %08h", name, expv, got);
            ok = 1'b0;
        end
    endtask

    task automatic tally_test(input string what, input bit ok);
        if (ok) begin
            $display("ok   %s", what);
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    task automatic wait_reset_release(input int limit, output bit done);
        int cnt;
        cnt = 0;
        while (rv_rst_ni !== 1'b1 && cnt < limit) begin
            @(posedge clk_i);
            cnt++;
        end
        done = (rv_rst_ni === 1'b1);
    endtask

    task automatic check_reset_state();
        bit ok;
        ok = 1'b1;
        check_word("pim_addr_o", '0, pim_addr_o, ok);
        check_word("pim_wr_o", '0, pim_wr_o, ok);
        check_word("rd_data_o", '0, rd_data_o, ok);
        tally_test("outputs zero after reset", ok);
    endtask

    task automatic run_table();
        mem_req_t req;
        vector_t  v;
        vector_t  pend;
        bit       pend_vld;
        bit       ok;
        pend_vld = 1'b0;
        for (int i = 0; i <= vectors.size(); i++) begin
            @(posedge clk_i);
            req = '0;
            if (i < vectors.size()) begin
                v = vectors[i];
                if (v.op == OP_WR || v.op == OP_RD) begin
                    req.read  = (v.op == OP_RD);
                    req.write = (v.op == OP_WR);
                    req.be    = v.be;
                    req.addr  = v.addr;
                    req.wdata = v.data;
                end else if (v.op == OP_PIMSET) begin
                    pim_rd_i <= v.data;
                end
            end
            req_i <= req;
            // Mid-cycle, the previous read's data is on rd_data_o
            @(negedge clk_i);
            if (pend_vld) begin
                ok = 1'b1;
                check_word("rd_data_o", pend.expv, rd_data_o, ok);
                tally_test($sformatf("read %08h -> %08h", pend.addr, pend.expv), ok);
            end
            pend_vld = 1'b0;
            if (i < vectors.size()) begin
                if (v.op == OP_RD) begin
                    pend     = v;
                    pend_vld = 1'b1;
                end else if (v.op == OP_PIMCHK) begin
                    ok = 1'b1;
                    check_word("pim_addr_o", v.addr, pim_addr_o, ok);
                    check_word("pim_wr_o", v.data, pim_wr_o, ok);
                    tally_test($sformatf("pim port %08h = %08h", v.addr, v.data), ok);
                end
            end
        end
    endtask

    initial begin
        req_i    = '0;
        pim_rd_i = '0;
        load_vectors();
        wait_reset_release(64, released);
        if (released) begin
            @(negedge clk_i);
            check_reset_state();
            run_table();
        end else begin
            $display("Reset was never released, no test could run");
        end
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (released && n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
